//--- src/vp_pkg.sv
`default_nettype none

package vp_pkg;

	//////////////////////////////
	// Clock enable ratios
	//////////////////////////////

	// System clocks per CPU pulse
	localparam logic [3:0] CPU_DIV_NTSC = 4'd8;
	localparam logic [3:0] CPU_DIV_PAL  = 4'd12;
	// System clocks per video chip pulse
	localparam logic [3:0] VDC_DIV_NTSC = 4'd6;
	localparam logic [3:0] VDC_DIV_PAL  = 4'd10;

	//////////////////////////////
	// Cartridge ROM
	//////////////////////////////

	localparam int CART_ADDR_W = 12;
	localparam int ROM_ADDR_W  = 14;
	localparam int ROM_DATA_W  = 8;

	// Image byte counts that pick a bank mapping
	localparam logic [15:0] CART_SIZE_4K  = 16'd4096;
	localparam logic [15:0] CART_SIZE_8K  = 16'd8192;
	localparam logic [15:0] CART_SIZE_16K = 16'd16384;

	// Index 0..2 loads the ROM, index 2 is an XROM image
	localparam logic [7:0] DL_INDEX_XROM  = 8'd2;
	localparam logic [7:0] DL_INDEX_LIMIT = 8'd3;

	//////////////////////////////
	// Colour output
	//////////////////////////////

	// RF palette, index is {r, g, b, luma}
	localparam logic [23:0] PALETTE_NTSC [16] = '{
		24'h000000, 24'h676767, 24'h1a37be, 24'h5c80f6,
		24'h006d07, 24'h56c469, 24'h2aaabe, 24'h77e6eb,
		24'h790000, 24'hc75151, 24'h94309f, 24'hdc84e8,
		24'h77670b, 24'hc6b86a, 24'hcecece, 24'hffffff
	};

	// RGB monitor palette
	localparam logic [23:0] PALETTE_PAL [16] = '{
		24'h000000, 24'h494949, 24'h0000b6, 24'h4949ff,
		24'h00b601, 24'h49ff49, 24'h00b6c9, 24'h49ffff,
		24'hb60000, 24'hff4949, 24'hb600b6, 24'hff49ff,
		24'hb6b600, 24'hffff49, 24'hb6b6b6, 24'hffffff
	};

	// Grey weights, sum is 256
	localparam logic [7:0] LUMA_W_R = 8'd77;
	localparam logic [7:0] LUMA_W_G = 8'd150;
	localparam logic [7:0] LUMA_W_B = 8'd29;

	//////////////////////////////
	// Host joystick word
	//////////////////////////////

	localparam int JOY_BIT_RIGHT  = 0;
	localparam int JOY_BIT_LEFT   = 1;
	localparam int JOY_BIT_DOWN   = 2;
	localparam int JOY_BIT_UP     = 3;
	localparam int JOY_BIT_ACTION = 4;
	localparam int JOY_BIT_RESET  = 5;
	// Keys 1..9 then 0 from here up to bit 15
	localparam int JOY_BIT_NUM0   = 6;

endpackage

`default_nettype wire

//--- src/vp_clock_enables.sv
`timescale 1ns/100ps
`default_nettype none

module vp_clock_enables (
	input  logic clk_sys,
	input  logic reset,
	input  logic pal_i,
	output logic cpu_en_o,
	output logic vdc_en_o
);

	import vp_pkg::*;

	// Terminal counts, slot 0 is the CPU, slot 1 the video chip
	logic [3:0] wrap_limit [2];
	logic [1:0] en_w;

	assign wrap_limit[0] = pal_i ? CPU_DIV_PAL - 4'd1 : CPU_DIV_NTSC - 4'd1;
	assign wrap_limit[1] = pal_i ? VDC_DIV_PAL - 4'd1 : VDC_DIV_NTSC - 4'd1;

	for (genvar i = 0; i < 2; i++) begin : g_div
		logic [3:0] count_q;
		logic       en_q;

		// Compare with >= so a shorter limit after a standard switch still wraps
		always_ff @(posedge clk_sys or posedge reset) begin
			if (reset) begin
				count_q <= 4'd0;
				en_q    <= 1'b0;
			end else if (count_q >= wrap_limit[i]) begin
				count_q <= 4'd0;
				en_q    <= 1'b1;
			end else begin
				count_q <= count_q + 4'd1;
				en_q    <= 1'b0;
			end
		end

		assign en_w[i] = en_q;
	end

	assign cpu_en_o = en_w[0];
	assign vdc_en_o = en_w[1];

endmodule

`default_nettype wire

//--- src/vp_cart_rom.sv
`timescale 1ns/100ps
`default_nettype none

module vp_cart_rom (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic                         dl_active_i,
	input  logic                         dl_wr_i,
	input  logic [7:0]                   dl_index_i,
	input  logic [vp_pkg::ROM_ADDR_W-1:0]  dl_addr_i,
	input  logic [vp_pkg::ROM_DATA_W-1:0]  dl_data_i,
	input  logic [vp_pkg::CART_ADDR_W-1:0] cart_addr_i,
	input  logic                         cart_bank0_i,
	input  logic                         cart_bank1_i,
	input  logic                         cart_rd_n_i,
	input  logic                         cart_cs_n_i,
	output logic [vp_pkg::ROM_DATA_W-1:0]  cart_data_o
);

	import vp_pkg::*;

	logic [ROM_DATA_W-1:0] rom_mem [2**ROM_ADDR_W];
	logic                  dl_active_q;
	logic [15:0]           cart_size_q;
	logic                  xrom_q;
	logic [ROM_ADDR_W-1:0] map_addr;
	logic [ROM_ADDR_W-1:0] rom_addr;
	logic                  rom_wr;
	logic                  rom_rd;

	//////////////////////////////
	// Download tracking
	//////////////////////////////

	// Start of a download restarts the byte count
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			cart_size_q <= 16'd0;
			xrom_q      <= 1'b0;
		end else begin
			dl_active_q <= dl_active_i;
			if (dl_active_i && !dl_active_q) begin
				cart_size_q <= 16'd0;
				xrom_q      <= (dl_index_i == DL_INDEX_XROM);
			end else if (dl_active_i && dl_wr_i) begin
				cart_size_q <= cart_size_q + 16'd1;
			end
		end
	end

	//////////////////////////////
	// Address map
	//////////////////////////////

	// Small images skip address bit 10 so they mirror
	always_comb begin
		if (xrom_q) begin
			map_addr = ROM_ADDR_W'(cart_addr_i);
		end else begin
			case (cart_size_q)
				CART_SIZE_4K:
					map_addr = ROM_ADDR_W'({cart_bank0_i, cart_addr_i[11], cart_addr_i[9:0]});
				CART_SIZE_8K:
					map_addr = ROM_ADDR_W'({cart_bank1_i, cart_bank0_i, cart_addr_i[11],
						cart_addr_i[9:0]});
				CART_SIZE_16K:
					map_addr = ROM_ADDR_W'({cart_bank1_i, cart_bank0_i, cart_addr_i[11:0]});
				default:
					map_addr = ROM_ADDR_W'({cart_addr_i[11], cart_addr_i[9:0]});
			endcase
		end
	end

	assign rom_addr = dl_active_i ? dl_addr_i : map_addr;
	assign rom_wr   = dl_wr_i && (dl_index_i < DL_INDEX_LIMIT);
	// XROM reads outside the bank0 chip-select window
	assign rom_rd   = xrom_q ? (cart_rd_n_i && !(cart_cs_n_i && cart_bank0_i)) : !cart_rd_n_i;

	// Array, single write port
	always_ff @(posedge clk_sys) begin
		if (rom_wr)
			rom_mem[dl_addr_i] <= dl_data_i;
	end

	// Read register holds between reads
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			cart_data_o <= '0;
		else if (rom_rd)
			cart_data_o <= rom_mem[rom_addr];
	end

endmodule

`default_nettype wire

//--- src/vp_input_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module vp_input_decoder (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [10:0] ps2_key_i,
	input  logic [15:0] joy_a_i,
	input  logic [15:0] joy_b_i,
	input  logic        joy_swap_i,
	output logic        key_ready_o,
	output logic [7:0]  key_ascii_o,
	output logic        key_released_o,
	output logic [1:0]  joy_up_n_o,
	output logic [1:0]  joy_down_n_o,
	output logic [1:0]  joy_left_n_o,
	output logic [1:0]  joy_right_n_o,
	output logic [1:0]  joy_action_n_o,
	output logic        joy_reset_n_o
);

	import vp_pkg::*;

	logic [15:0] player_a;
	logic [15:0] player_b;
	logic [9:0]  numpad;
	logic [9:0]  numpad_q;
	logic        toggle_q;
	logic        ps2_event;
	logic        pad_event;

	// Scancode to keyboard character, zero when unmapped
	function automatic logic [7:0] scan_to_ascii(input logic [7:0] code);
		case (code)
			8'h16: return "1";
			8'h1e: return "2";
			8'h26: return "3";
			8'h25: return "4";
			8'h2e: return "5";
			8'h36: return "6";
			8'h3d: return "7";
			8'h3e: return "8";
			8'h46: return "9";
			8'h45: return "0";
			8'h1c: return "a";
			8'h32: return "b";
			8'h21: return "c";
			8'h23: return "d";
			8'h24: return "e";
			8'h2b: return "f";
			8'h34: return "g";
			8'h33: return "h";
			8'h43: return "i";
			8'h3b: return "j";
			8'h42: return "k";
			8'h4b: return "l";
			8'h3a: return "m";
			8'h31: return "n";
			8'h44: return "o";
			8'h4d: return "p";
			8'h15: return "q";
			8'h2d: return "r";
			8'h1b: return "s";
			8'h2c: return "t";
			8'h3c: return "u";
			8'h2a: return "v";
			8'h1d: return "w";
			8'h22: return "x";
			8'h35: return "y";
			8'h1a: return "z";
			8'h29: return " ";
			8'h79: return "+";
			8'h7b: return "-";
			8'h7c: return "*";
			8'h4a: return "/";
			8'h55: return "=";
			// GUI keys act as yes and no
			8'h1f: return 8'h11;
			8'h27: return 8'h12;
			8'h5a: return 8'h0a;
			8'h66: return 8'h08;
			default: return 8'h00;
		endcase
	endfunction

	// Lowest pressed pad key wins
	function automatic logic [7:0] pad_to_ascii(input logic [9:0] pad);
		logic [7:0] digit;
		digit = 8'h00;
		for (int i = 9; i >= 0; i--) begin
			if (pad[i])
				digit = (i == 9) ? "0" : 8'("1" + i);
		end
		return digit;
	endfunction

	//////////////////////////////
	// Joystick routing
	//////////////////////////////

	assign player_a = joy_swap_i ? joy_b_i : joy_a_i;
	assign player_b = joy_swap_i ? joy_a_i : joy_b_i;

	// Active low, player A on bit 1
	assign joy_up_n_o     = ~{player_a[JOY_BIT_UP], player_b[JOY_BIT_UP]};
	assign joy_down_n_o   = ~{player_a[JOY_BIT_DOWN], player_b[JOY_BIT_DOWN]};
	assign joy_left_n_o   = ~{player_a[JOY_BIT_LEFT], player_b[JOY_BIT_LEFT]};
	assign joy_right_n_o  = ~{player_a[JOY_BIT_RIGHT], player_b[JOY_BIT_RIGHT]};
	assign joy_action_n_o = ~{player_a[JOY_BIT_ACTION], player_b[JOY_BIT_ACTION]};
	assign joy_reset_n_o  = ~(player_a[JOY_BIT_RESET] && player_b[JOY_BIT_RESET]);

	//////////////////////////////
	// Keyboard events
	//////////////////////////////

	// Either pad can type digits
	assign numpad    = joy_a_i[15:JOY_BIT_NUM0] | joy_b_i[15:JOY_BIT_NUM0];
	assign ps2_event = (ps2_key_i[10] != toggle_q);
	assign pad_event = (numpad != numpad_q);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			toggle_q       <= 1'b0;
			numpad_q       <= '0;
			key_ready_o    <= 1'b0;
			key_released_o <= 1'b1;
		end else begin
			toggle_q       <= ps2_key_i[10];
			numpad_q       <= numpad;
			key_ready_o    <= ps2_event || pad_event;
			key_released_o <= !ps2_key_i[9] && (numpad == '0);
		end
	end

	// PS/2 has priority over the pads
	always_ff @(posedge clk_sys) begin
		if (ps2_event)
			key_ascii_o <= scan_to_ascii(ps2_key_i[7:0]);
		else if (pad_event)
			key_ascii_o <= pad_to_ascii(numpad);
	end

endmodule

`default_nettype wire

//--- src/vp_color_out.sv
`timescale 1ns/100ps
`default_nettype none

module vp_color_out (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        red_i,
	input  logic        green_i,
	input  logic        blue_i,
	input  logic        luma_i,
	input  logic        palette_rgb_i,
	input  logic        mono_i,
	output logic [23:0] rgb_o
);

	import vp_pkg::*;

	logic [3:0]  color_idx;
	logic [23:0] color_q;
	logic        mono_q;
	logic [15:0] grey_sum;
	logic [7:0]  grey;

	assign color_idx = {red_i, green_i, blue_i, luma_i};

	//////////////////////////////
	// Stage 1, palette lookup
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		color_q <= palette_rgb_i ? PALETTE_PAL[color_idx] : PALETTE_NTSC[color_idx];
		mono_q  <= mono_i;
	end

	//////////////////////////////
	// Stage 2, grey or colour
	//////////////////////////////

	// Weighted sum fits 16 bits since the weights add to 256
	assign grey_sum = {8'd0, LUMA_W_R} * {8'd0, color_q[23:16]}
		+ {8'd0, LUMA_W_G} * {8'd0, color_q[15:8]}
		+ {8'd0, LUMA_W_B} * {8'd0, color_q[7:0]};
	assign grey     = grey_sum[15:8];

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			rgb_o <= 24'd0;
		else if (mono_q)
			rgb_o <= {grey, grey, grey};
		else
			rgb_o <= color_q;
	end

endmodule

`default_nettype wire

//--- src/vp_glue_top.sv
`timescale 1ns/100ps
`default_nettype none

module vp_glue_top (
	input  logic                           clk_sys,
	input  logic                           reset,
	// Clock enables
	input  logic                           pal_i,
	output logic                           cpu_en_o,
	output logic                           vdc_en_o,
	// Cartridge download and bus
	input  logic                           dl_active_i,
	input  logic                           dl_wr_i,
	input  logic [7:0]                     dl_index_i,
	input  logic [vp_pkg::ROM_ADDR_W-1:0]  dl_addr_i,
	input  logic [vp_pkg::ROM_DATA_W-1:0]  dl_data_i,
	input  logic [vp_pkg::CART_ADDR_W-1:0] cart_addr_i,
	input  logic                           cart_bank0_i,
	input  logic                           cart_bank1_i,
	input  logic                           cart_rd_n_i,
	input  logic                           cart_cs_n_i,
	output logic [vp_pkg::ROM_DATA_W-1:0]  cart_data_o,
	// Keyboard and joysticks
	input  logic [10:0]                    ps2_key_i,
	input  logic [15:0]                    joy_a_i,
	input  logic [15:0]                    joy_b_i,
	input  logic                           joy_swap_i,
	output logic                           key_ready_o,
	output logic [7:0]                     key_ascii_o,
	output logic                           key_released_o,
	output logic [1:0]                     joy_up_n_o,
	output logic [1:0]                     joy_down_n_o,
	output logic [1:0]                     joy_left_n_o,
	output logic [1:0]                     joy_right_n_o,
	output logic [1:0]                     joy_action_n_o,
	output logic                           joy_reset_n_o,
	// Video colour
	input  logic                           red_i,
	input  logic                           green_i,
	input  logic                           blue_i,
	input  logic                           luma_i,
	input  logic                           palette_rgb_i,
	input  logic                           mono_i,
	output logic [23:0]                    rgb_o
);

	vp_clock_enables u_clock_enables (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.pal_i    (pal_i),
		.cpu_en_o (cpu_en_o),
		.vdc_en_o (vdc_en_o)
	);

	vp_cart_rom u_cart_rom (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_active_i  (dl_active_i),
		.dl_wr_i      (dl_wr_i),
		.dl_index_i   (dl_index_i),
		.dl_addr_i    (dl_addr_i),
		.dl_data_i    (dl_data_i),
		.cart_addr_i  (cart_addr_i),
		.cart_bank0_i (cart_bank0_i),
		.cart_bank1_i (cart_bank1_i),
		.cart_rd_n_i  (cart_rd_n_i),
		.cart_cs_n_i  (cart_cs_n_i),
		.cart_data_o  (cart_data_o)
	);

	vp_input_decoder u_input_decoder (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ps2_key_i      (ps2_key_i),
		.joy_a_i        (joy_a_i),
		.joy_b_i        (joy_b_i),
		.joy_swap_i     (joy_swap_i),
		.key_ready_o    (key_ready_o),
		.key_ascii_o    (key_ascii_o),
		.key_released_o (key_released_o),
		.joy_up_n_o     (joy_up_n_o),
		.joy_down_n_o   (joy_down_n_o),
		.joy_left_n_o   (joy_left_n_o),
		.joy_right_n_o  (joy_right_n_o),
		.joy_action_n_o (joy_action_n_o),
		.joy_reset_n_o  (joy_reset_n_o)
	);

	vp_color_out u_color_out (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.red_i         (red_i),
		.green_i       (green_i),
		.blue_i        (blue_i),
		.luma_i        (luma_i),
		.palette_rgb_i (palette_rgb_i),
		.mono_i        (mono_i),
		.rgb_o         (rgb_o)
	);

endmodule

`default_nettype wire

//--- testbench/tb_vp_glue.sv
`timescale 1ns/100ps
`default_nettype none

module tb_vp_glue;

	import vp_pkg::*;

	// Keyboard scancodes, each paired with the character at the same slot below
	localparam logic [7:0] SCAN_CODES [46] = '{
		8'h16, 8'h1e, 8'h26, 8'h25, 8'h2e, 8'h36, 8'h3d, 8'h3e, 8'h46, 8'h45,
		8'h1c, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2b, 8'h34, 8'h33, 8'h43, 8'h3b,
		8'h42, 8'h4b, 8'h3a, 8'h31, 8'h44, 8'h4d, 8'h15, 8'h2d, 8'h1b, 8'h2c,
		8'h3c, 8'h2a, 8'h1d, 8'h22, 8'h35, 8'h1a, 8'h29, 8'h79, 8'h7b, 8'h7c,
		8'h4a, 8'h55, 8'h1f, 8'h27, 8'h5a, 8'h66
	};
	// Last four are yes, no, enter and backspace
	localparam logic [7:0] SCAN_CHARS [46] = '{
		"1", "2", "3", "4", "5", "6", "7", "8", "9", "0",
		"a", "b", "c", "d", "e", "f", "g", "h", "i", "j",
		"k", "l", "m", "n", "o", "p", "q", "r", "s", "t",
		"u", "v", "w", "x", "y", "z", " ", "+", "-", "*",
		"/", "=", 8'h11, 8'h12, 8'h0a, 8'h08
	};

	logic                   clk_sys = 1'b0;
	logic                   reset;
	logic                   pal_i;
	logic                   cpu_en_o;
	logic                   vdc_en_o;
	logic                   dl_active_i;
	logic                   dl_wr_i;
	logic [7:0]             dl_index_i;
	logic [ROM_ADDR_W-1:0]  dl_addr_i;
	logic [ROM_DATA_W-1:0]  dl_data_i;
	logic [CART_ADDR_W-1:0] cart_addr_i;
	logic                   cart_bank0_i;
	logic                   cart_bank1_i;
	logic                   cart_rd_n_i;
	logic                   cart_cs_n_i;
	logic [ROM_DATA_W-1:0]  cart_data_o;
	logic [10:0]            ps2_key_i;
	logic [15:0]            joy_a_i;
	logic [15:0]            joy_b_i;
	logic                   joy_swap_i;
	logic                   key_ready_o;
	logic [7:0]             key_ascii_o;
	logic                   key_released_o;
	logic [1:0]             joy_up_n_o;
	logic [1:0]             joy_down_n_o;
	logic [1:0]             joy_left_n_o;
	logic [1:0]             joy_right_n_o;
	logic [1:0]             joy_action_n_o;
	logic                   joy_reset_n_o;
	logic                   red_i;
	logic                   green_i;
	logic                   blue_i;
	logic                   luma_i;
	logic                   palette_rgb_i;
	logic                   mono_i;
	logic [23:0]            rgb_o;

	// Cartridge model state
	logic [ROM_DATA_W-1:0]  rom_model [2**ROM_ADDR_W];
	int                     size_model;
	logic                   xrom_model;
	logic [ROM_DATA_W-1:0]  data_model;

	vp_glue_top DUT (.*);

	always #2 clk_sys = ~clk_sys;

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic abort_run(input string why);
		if (why.len() > 0)
			$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERROR %s expected %h got %h", name, exp, act);
			abort_run("");
		end
	endtask

	task automatic check_pair(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp) begin
			$display("ERROR %s expected %h got %h", name, exp, act);
			abort_run("");
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("ERROR %s expected %h got %h", name, exp, act);
			abort_run("");
		end
	endtask

	task automatic check_rgb(input string name, input logic [23:0] exp, input logic [23:0] act);
		if (act !== exp) begin
			$display("ERROR %s expected %h got %h", name, exp, act);
			abort_run("");
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("ERROR %s expected %h got %h", name, exp, act);
			abort_run("");
		end
	endtask

	//////////////////////////////
	// Clock enables
	//////////////////////////////

	// Gap between pulses, first pulse only starts the count
	task automatic check_enable_spacing(input logic pal, input int cpu_div, input int vdc_div);
		int cpu_gap;
		int vdc_gap;
		int cpu_seen;
		int vdc_seen;
		@(posedge clk_sys);
		pal_i <= pal;
		repeat (2 * CPU_DIV_PAL) @(posedge clk_sys);
		cpu_gap  = 0;
		vdc_gap  = 0;
		cpu_seen = 0;
		vdc_seen = 0;
		for (int n = 0; n < 240; n++) begin
			@(negedge clk_sys);
			cpu_gap++;
			vdc_gap++;
			if (cpu_en_o) begin
				if (cpu_seen > 0)
					check_count("cpu_en_o spacing", cpu_div, cpu_gap);
				cpu_seen++;
				cpu_gap = 0;
			end
			if (vdc_en_o) begin
				if (vdc_seen > 0)
					check_count("vdc_en_o spacing", vdc_div, vdc_gap);
				vdc_seen++;
				vdc_gap = 0;
			end
		end
		if (cpu_seen < 10 || vdc_seen < 10)
			abort_run("Too few clock enable pulses within the measuring window");
	endtask

	//////////////////////////////
	// Cartridge ROM
	//////////////////////////////

	// Bank folding per image size
	function automatic int map_cart_addr(input logic [11:0] addr, input logic b0, input logic b1);
		int a11;
		int low10;
		a11   = int'(addr[11]);
		low10 = int'(addr[9:0]);
		if (xrom_model)
			return int'(addr);
		if (size_model == int'(CART_SIZE_4K))
			return int'(b0) * 2048 + a11 * 1024 + low10;
		if (size_model == int'(CART_SIZE_8K))
			return int'(b1) * 4096 + int'(b0) * 2048 + a11 * 1024 + low10;
		if (size_model == int'(CART_SIZE_16K))
			return int'(b1) * 8192 + int'(b0) * 4096 + int'(addr);
		return a11 * 1024 + low10;
	endfunction

	// Sequential image, bus held idle so no read fires
	task automatic download_image(input logic [7:0] index, input int n_bytes);
		logic [7:0] value;
		@(posedge clk_sys);
		cart_rd_n_i  <= 1'b1;
		cart_cs_n_i  <= 1'b1;
		cart_bank0_i <= 1'b1;
		dl_active_i  <= 1'b1;
		dl_index_i   <= index;
		for (int a = 0; a < n_bytes; a++) begin
			value = 8'($urandom);
			@(posedge clk_sys);
			dl_wr_i   <= 1'b1;
			dl_addr_i <= ROM_ADDR_W'(a);
			dl_data_i <= value;
			if (index < DL_INDEX_LIMIT)
				rom_model[ROM_ADDR_W'(a)] = value;
		end
		@(posedge clk_sys);
		dl_wr_i     <= 1'b0;
		dl_active_i <= 1'b0;
		size_model = n_bytes;
		xrom_model = (index == DL_INDEX_XROM);
	endtask

	task automatic cart_read();
		logic [11:0] addr;
		logic        b0;
		logic        b1;
		logic        rd_n;
		logic        cs_n;
		logic        rd_en;
		addr = 12'($urandom);
		b0   = 1'($urandom);
		b1   = 1'($urandom);
		cs_n = 1'($urandom);
		// XROM reads want rd_n high, normal reads want it low
		rd_n = xrom_model ? ($urandom % 4 != 0) : ($urandom % 4 == 0);
		rd_en = xrom_model ? (rd_n && !(cs_n && b0)) : !rd_n;
		@(posedge clk_sys);
		cart_addr_i  <= addr;
		cart_bank0_i <= b0;
		cart_bank1_i <= b1;
		cart_rd_n_i  <= rd_n;
		cart_cs_n_i  <= cs_n;
		if (rd_en)
			data_model = rom_model[ROM_ADDR_W'(map_cart_addr(addr, b0, b1))];
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_byte("cart_data_o", data_model, cart_data_o);
	endtask

	//////////////////////////////
	// Keyboard and joysticks
	//////////////////////////////

	function automatic logic [7:0] expected_char(input logic [7:0] code);
		for (int i = 0; i < 46; i++) begin
			if (SCAN_CODES[6'(i)] == code)
				return SCAN_CHARS[6'(i)];
		end
		return 8'h00;
	endfunction

	function automatic logic [9:0] random_pad();
		case ($urandom % 4)
			0: return 10'd0;
			1: return 10'd1 << ($urandom % 10);
			default: return 10'($urandom);
		endcase
	endfunction

	// Waits for the event strobe at falling edges
	task automatic wait_key_ready();
		int n;
		n = 0;
		@(negedge clk_sys);
		while (!key_ready_o) begin
			if (n == 20)
				abort_run("key_ready_o did not pulse after a key event");
			n++;
			@(negedge clk_sys);
		end
	endtask

	task automatic expect_key(input logic [7:0] exp_ascii, input logic exp_released);
		wait_key_ready();
		check_byte("key_ascii_o", exp_ascii, key_ascii_o);
		check_bit("key_released_o", exp_released, key_released_o);
		// Strobe lasts one cycle
		@(negedge clk_sys);
		check_bit("key_ready_o", 1'b0, key_ready_o);
	endtask

	task automatic send_ps2_key();
		logic [7:0] code;
		logic       pressed;
		logic [9:0] pad;
		if ($urandom % 2 == 0)
			code = SCAN_CODES[6'($urandom % 46)];
		else
			code = 8'($urandom);
		pressed = 1'($urandom);
		pad     = joy_a_i[15:JOY_BIT_NUM0] | joy_b_i[15:JOY_BIT_NUM0];
		@(posedge clk_sys);
		ps2_key_i <= {!ps2_key_i[10], pressed, 1'($urandom), code};
		expect_key(expected_char(code), !pressed && pad == 10'd0);
	endtask

	task automatic change_numpad();
		logic [9:0] old_pad;
		logic [9:0] new_a;
		logic [9:0] new_b;
		logic [9:0] scan;
		logic [7:0] exp_ascii;
		old_pad = joy_a_i[15:JOY_BIT_NUM0] | joy_b_i[15:JOY_BIT_NUM0];
		new_a   = random_pad();
		new_b   = random_pad();
		// An unchanged pad gives no event
		if ((new_a | new_b) == old_pad) begin
			new_a = old_pad ^ (10'd1 << ($urandom % 10));
			new_b = 10'd0;
		end
		scan      = new_a | new_b;
		exp_ascii = 8'h00;
		for (int i = 0; i < 10; i++) begin
			if (scan[0] && exp_ascii == 8'h00)
				exp_ascii = (i == 9) ? "0" : 8'("1" + i);
			scan = scan >> 1;
		end
		@(posedge clk_sys);
		joy_a_i <= {new_a, joy_a_i[JOY_BIT_NUM0-1:0]};
		joy_b_i <= {new_b, joy_b_i[JOY_BIT_NUM0-1:0]};
		expect_key(exp_ascii, !ps2_key_i[9] && (new_a | new_b) == 10'd0);
	endtask

	// Player A lands on bit 1
	task automatic check_joy_routing();
		logic [15:0] pa;
		logic [15:0] pb;
		@(posedge clk_sys);
		joy_a_i    <= 16'($urandom);
		joy_b_i    <= 16'($urandom);
		joy_swap_i <= 1'($urandom);
		@(negedge clk_sys);
		pa = joy_swap_i ? joy_b_i : joy_a_i;
		pb = joy_swap_i ? joy_a_i : joy_b_i;
		check_pair("joy_up_n_o", {!pa[JOY_BIT_UP], !pb[JOY_BIT_UP]}, joy_up_n_o);
		check_pair("joy_down_n_o", {!pa[JOY_BIT_DOWN], !pb[JOY_BIT_DOWN]}, joy_down_n_o);
		check_pair("joy_left_n_o", {!pa[JOY_BIT_LEFT], !pb[JOY_BIT_LEFT]}, joy_left_n_o);
		check_pair("joy_right_n_o", {!pa[JOY_BIT_RIGHT], !pb[JOY_BIT_RIGHT]}, joy_right_n_o);
		check_pair("joy_action_n_o", {!pa[JOY_BIT_ACTION], !pb[JOY_BIT_ACTION]},
			joy_action_n_o);
		check_bit("joy_reset_n_o", !(pa[JOY_BIT_RESET] && pb[JOY_BIT_RESET]), joy_reset_n_o);
	endtask

	//////////////////////////////
	// Colour output
	//////////////////////////////

	function automatic logic [23:0] expected_rgb(input logic [3:0] idx, input logic rgb_pal,
		input logic mono);
		logic [23:0] c;
		int          grey;
		c = rgb_pal ? PALETTE_PAL[idx] : PALETTE_NTSC[idx];
		if (!mono)
			return c;
		grey = (int'(LUMA_W_R) * int'(c[23:16]) + int'(LUMA_W_G) * int'(c[15:8])
			+ int'(LUMA_W_B) * int'(c[7:0])) >> 8;
		return {3{8'(grey)}};
	endfunction

	// New sample every cycle, result due two edges later
	task automatic color_stream(input int n_samples);
		logic [23:0] pending [$];
		logic [3:0]  idx;
		logic        pal_sel;
		logic        mono;
		for (int j = 0; j < n_samples; j++) begin
			idx     = 4'($urandom);
			pal_sel = 1'($urandom);
			mono    = 1'($urandom);
			@(posedge clk_sys);
			red_i         <= idx[3];
			green_i       <= idx[2];
			blue_i        <= idx[1];
			luma_i        <= idx[0];
			palette_rgb_i <= pal_sel;
			mono_i        <= mono;
			pending.push_back(expected_rgb(idx, pal_sel, mono));
			@(negedge clk_sys);
			if (pending.size() == 3)
				check_rgb("rgb_o", pending.pop_front(), rgb_o);
		end
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		void'($urandom(32'hdc0d));
		size_model = 0;
		xrom_model = 1'b0;
		data_model = 8'h00;
		reset         <= 1'b1;
		pal_i         <= 1'b0;
		dl_active_i   <= 1'b0;
		dl_wr_i       <= 1'b0;
		dl_index_i    <= 8'd0;
		dl_addr_i     <= '0;
		dl_data_i     <= '0;
		cart_addr_i   <= '0;
		cart_bank0_i  <= 1'b1;
		cart_bank1_i  <= 1'b0;
		cart_rd_n_i   <= 1'b1;
		cart_cs_n_i   <= 1'b1;
		ps2_key_i     <= 11'd0;
		joy_a_i       <= 16'd0;
		joy_b_i       <= 16'd0;
		joy_swap_i    <= 1'b0;
		red_i         <= 1'b0;
		green_i       <= 1'b0;
		blue_i        <= 1'b0;
		luma_i        <= 1'b0;
		palette_rgb_i <= 1'b0;
		mono_i        <= 1'b0;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);

		// Quiet outputs out of reset
		check_bit("cpu_en_o", 1'b0, cpu_en_o);
		check_bit("vdc_en_o", 1'b0, vdc_en_o);
		check_bit("key_ready_o", 1'b0, key_ready_o);
		check_rgb("rgb_o", 24'd0, rgb_o);
		check_byte("cart_data_o", 8'h00, cart_data_o);

		check_enable_spacing(1'b0, int'(CPU_DIV_NTSC), int'(VDC_DIV_NTSC));
		check_enable_spacing(1'b1, int'(CPU_DIV_PAL), int'(VDC_DIV_PAL));
		check_enable_spacing(1'b0, int'(CPU_DIV_NTSC), int'(VDC_DIV_NTSC));

		// One image per size class, 2K first
		download_image(8'($urandom % 2), 2048);
		repeat (200) cart_read();
		download_image(8'($urandom % 2), int'(CART_SIZE_4K));
		repeat (200) cart_read();
		download_image(8'($urandom % 2), int'(CART_SIZE_8K));
		repeat (300) cart_read();
		download_image(8'($urandom % 2), int'(CART_SIZE_16K));
		repeat (400) cart_read();
		// XROM image, then a stream the ROM must ignore
		download_image(DL_INDEX_XROM, int'(CART_SIZE_4K));
		repeat (300) cart_read();
		download_image(8'(DL_INDEX_LIMIT + 8'($urandom % 200)), int'(CART_SIZE_16K));
		repeat (400) cart_read();

		repeat (300) begin
			if ($urandom % 2 == 0)
				send_ps2_key();
			else
				change_numpad();
		end

		repeat (200) check_joy_routing();
		color_stream(500);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
src/vp_pkg.sv
src/vp_clock_enables.sv
src/vp_cart_rom.sv
src/vp_input_decoder.sv
src/vp_color_out.sv
src/vp_glue_top.sv
testbench/tb_vp_glue.sv

//--- Makefile
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timescale 1ns/100ps --top-module tb_vp_glue -f sim.f --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/Vtb_vp_glue

clean:
	rm -rf $(BUILD_DIR)
